// File: rtl/bank_result_merge.sv
/* Bank result merge
   Combines per-bank status into global allocation, search and occupancy outputs */

module bank_result_merge (
  input  tag_dir_pkg::bank_status_t bank_status [tag_dir_pkg::NUM_BANKS],
  input  tag_dir_pkg::bank_t        home_bank,
  output tag_dir_pkg::dir_index_t   alloc_index,
  output logic                      alloc_blocked,
  output logic                      search_hit,
  output tag_dir_pkg::dir_index_t   search_index,
  output logic                      full,
  output logic                      empty
);

  import tag_dir_pkg::*;

  // Status of the bank the current allocation maps to
  bank_status_t home_status;

  assign home_status = bank_status[home_bank];

  // Allocation result, blocked regardless of the enable
  always_comb begin
    alloc_index.bank = home_bank;
    alloc_index.slot = home_status.free_slot;
    alloc_blocked    = home_status.full;
  end

  // Search across banks, lowest bank wins
  always_comb begin
    search_hit   = 1'b0;
    search_index = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (bank_status[b].hit && !search_hit) begin
        search_hit        = 1'b1;
        search_index.bank = bank_t'(b);
        search_index.slot = bank_status[b].hit_slot;
      end
    end
  end

  // Occupancy reduction
  always_comb begin
    full  = 1'b1;
    empty = 1'b1;
    for (int b = 0; b < NUM_BANKS; b++) begin
      // Every bank must agree
      full  = full  && bank_status[b].full;
      empty = empty && bank_status[b].empty;
    end
  end

endmodule

// File: rtl/bank_steering.sv
/* Bank steering
   Sends allocations to the tag's home bank and decodes evictions to a single bank */

module bank_steering (
  input  tag_dir_pkg::alloc_req_t   alloc,
  input  tag_dir_pkg::evict_req_t   evict,
  input  tag_dir_pkg::bank_status_t bank_status [tag_dir_pkg::NUM_BANKS],
  output tag_dir_pkg::alloc_req_t   bank_alloc  [tag_dir_pkg::NUM_BANKS],
  output tag_dir_pkg::evict_req_t   bank_evict  [tag_dir_pkg::NUM_BANKS],
  output tag_dir_pkg::bank_t        home_bank
);

  import tag_dir_pkg::*;

  // Home bank comes from the low tag bits
  assign home_bank = alloc.tag[BANK_BITS-1:0];

  // Allocation routing
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      // Tag is shared, only the enable is steered
      bank_alloc[b].tag = alloc.tag;
      // A full home bank drops the request
      bank_alloc[b].enable = alloc.enable
                          && (home_bank == bank_t'(b))
                          && !bank_status[b].full;
    end
  end

  // Eviction decode
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      // Full index travels along, bank uses the slot part
      bank_evict[b].index  = evict.index;
      bank_evict[b].enable = evict.enable && (evict.index.bank == bank_t'(b));
    end
  end

endmodule

// File: rtl/first_set_index.sv
/* First set index
   Binary position of the lowest set bit in a slot vector, plus an any-set flag */

module first_set_index (
  input  logic [tag_dir_pkg::BANK_DEPTH-1:0] bits,
  output tag_dir_pkg::slot_t                 position,
  output logic                               any
);

  import tag_dir_pkg::*;

  // Scan upward, keep the first hit only
  always_comb begin
    position = '0;
    any      = 1'b0;
    for (int i = 0; i < BANK_DEPTH; i++) begin
      if (bits[i] && !any) begin
        position = slot_t'(i);
        any      = 1'b1;
      end
    end
  end

  // Position stays at 0 when nothing is set

endmodule

// File: rtl/tag_dir_pkg.sv
/* Tag directory package
   Sizes, index and request types, and per-bank status shared by the banked directory */

package tag_dir_pkg;

  // Bank organisation
  localparam int NUM_BANKS  = 4;
  localparam int BANK_BITS  = 2;

  // Slots inside one bank
  localparam int BANK_DEPTH = 8;
  localparam int SLOT_BITS  = 3;

  // Stored tag width
  localparam int TAG_WIDTH  = 12;

  typedef logic [TAG_WIDTH-1:0] tag_t;
  typedef logic [BANK_BITS-1:0] bank_t;
  typedef logic [SLOT_BITS-1:0] slot_t;

  // Global directory index, bank in the upper bits
  typedef struct packed {
    bank_t bank;
    slot_t slot;
  } dir_index_t;

  // Allocation strobe with its tag
  typedef struct packed {
    logic  enable;
    tag_t  tag;
  } alloc_req_t;

  // Eviction strobe with the global index to free
  typedef struct packed {
    logic       enable;
    dir_index_t index;
  } evict_req_t;

  // Everything one bank reports back to the merge logic
  typedef struct packed {
    logic  full;
    logic  empty;
    slot_t free_slot;  // lowest free slot, 0 when full
    logic  hit;
    slot_t hit_slot;   // lowest matching slot, 0 on a miss
  } bank_status_t;

endpackage

// File: rtl/tag_dir_top.sv
/* Banked tag directory top
   Steering, four directory banks and result merge wired together */

module tag_dir_top (
  input  logic                    clock,
  input  logic                    resetn,
  input  tag_dir_pkg::alloc_req_t alloc,
  input  tag_dir_pkg::tag_t       search_tag,
  input  tag_dir_pkg::evict_req_t evict,
  output tag_dir_pkg::dir_index_t alloc_index,
  output logic                    alloc_blocked,
  output logic                    search_hit,
  output tag_dir_pkg::dir_index_t search_index,
  output logic                    full,
  output logic                    empty
);

  import tag_dir_pkg::*;

  // Per-bank request and status buses
  alloc_req_t   bank_alloc  [NUM_BANKS];
  evict_req_t   bank_evict  [NUM_BANKS];
  bank_status_t bank_status [NUM_BANKS];
  bank_t        home_bank;

  // Request steering into the banks
  bank_steering u_steering (
    .alloc       ( alloc       ),
    .evict       ( evict       ),
    .bank_status ( bank_status ),
    .bank_alloc  ( bank_alloc  ),
    .bank_evict  ( bank_evict  ),
    .home_bank   ( home_bank   )
  );

  // Banks, search tag broadcast to all
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    tag_directory u_bank (
      .clock      ( clock          ),
      .resetn     ( resetn         ),
      .alloc      ( bank_alloc[b]  ),
      .search_tag ( search_tag     ),
      .evict      ( bank_evict[b]  ),
      .status     ( bank_status[b] )
    );
  end

  // Global results
  bank_result_merge u_merge (
    .bank_status   ( bank_status   ),
    .home_bank     ( home_bank     ),
    .alloc_index   ( alloc_index   ),
    .alloc_blocked ( alloc_blocked ),
    .search_hit    ( search_hit    ),
    .search_index  ( search_index  ),
    .full          ( full          ),
    .empty         ( empty         )
  );

endmodule

// File: rtl/tag_directory.sv
/* Tag directory bank
   Stores tags with valid bits; allocates to the first free slot, searches and evicts */

module tag_directory (
  input  logic                      clock,
  input  logic                      resetn,
  input  tag_dir_pkg::alloc_req_t   alloc,
  input  tag_dir_pkg::tag_t         search_tag,
  input  tag_dir_pkg::evict_req_t   evict,
  output tag_dir_pkg::bank_status_t status
);

  import tag_dir_pkg::*;

  // Tag storage and per-slot valid bits
  tag_t                  tags [BANK_DEPTH];
  logic [BANK_DEPTH-1:0] valid;

  // Free slot lookup
  slot_t free_slot;
  logic  has_free;

  // Search lookup
  logic [BANK_DEPTH-1:0] match;
  slot_t                 hit_slot;
  logic                  hit;

  // Lowest invalid slot is the allocation target
  first_set_index u_free_finder (
    .bits     ( ~valid    ),
    .position ( free_slot ),
    .any      ( has_free  )
  );

  // Compare the search tag against every valid entry
  always_comb begin
    for (int i = 0; i < BANK_DEPTH; i++) begin
      match[i] = valid[i] && (tags[i] == search_tag);
    end
  end

  // Duplicates resolve to the lowest slot
  first_set_index u_hit_finder (
    .bits     ( match    ),
    .position ( hit_slot ),
    .any      ( hit      )
  );

  // Eviction applied last so it overrides a same-slot allocation
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      valid <= '0;
    end else begin
      if (alloc.enable && has_free) begin
        valid[free_slot] <= 1'b1;
      end
      if (evict.enable) begin
        valid[evict.index.slot] <= 1'b0;
      end
    end
  end

  // Tag write into the allocated slot
  always_ff @(posedge clock) begin
    if (alloc.enable && has_free) begin
      tags[free_slot] <= alloc.tag;
    end
  end

  // Pack the bank report
  always_comb begin
    status.full      = !has_free;
    status.empty     = ~|valid;
    status.free_slot = free_slot;
    status.hit       = hit;
    status.hit_slot  = hit_slot;
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the tag directory testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --top-module tag_dir_tb -f sim.f -o tag_dir_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tag_dir_sim > sim.log 2>&1
cat sim.log
grep -q "RESULT: PASS" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }

// File: sim.f
rtl/tag_dir_pkg.sv
rtl/first_set_index.sv
rtl/tag_directory.sv
rtl/bank_steering.sv
rtl/bank_result_merge.sv
rtl/tag_dir_top.sv
sim/tag_dir_tb.sv

// File: sim/tag_dir_tb.sv
/* Banked tag directory testbench
   Random allocate, search and evict traffic checked against a reference model */

module tag_dir_tb;

  import tag_dir_pkg::*;

  // Run length and phase boundaries
  localparam int RESET_CYCLES = 5;
  localparam int RUN_CYCLES   = 2000;
  localparam int FILL_END     = 500;
  localparam int DRAIN_END    = 1000;
  localparam int POOL_SIZE    = 24;

  logic         clock;
  logic         resetn;
  alloc_req_t   alloc;
  tag_t         search_tag;
  evict_req_t   evict;
  dir_index_t   alloc_index;
  logic         alloc_blocked;
  logic         search_hit;
  dir_index_t   search_index;
  logic         full;
  logic         empty;

  // Reference model state
  logic         m_valid [NUM_BANKS][BANK_DEPTH];
  tag_t         m_tags  [NUM_BANKS][BANK_DEPTH];
  tag_t         last_alloc_tag;

  // Expected responses for the current cycle
  dir_index_t   exp_alloc_index;
  logic         exp_blocked;
  logic         exp_hit;
  dir_index_t   exp_search_index;
  logic         exp_full;
  logic         exp_empty;

  int           seen_full;
  int           seen_drained;
  int           seen_blocked;
  int           seen_hit;
  int           seen_collision;

  tag_dir_top UUT (
    .clock         ( clock         ),
    .resetn        ( resetn        ),
    .alloc         ( alloc         ),
    .search_tag    ( search_tag    ),
    .evict         ( evict         ),
    .alloc_index   ( alloc_index   ),
    .alloc_blocked ( alloc_blocked ),
    .search_hit    ( search_hit    ),
    .search_index  ( search_index  ),
    .full          ( full          ),
    .empty         ( empty         )
  );

  always #4 clock = ~clock;

  // Pool spreads evenly over the four home banks
  function automatic tag_t pool_tag(input int n);
    return tag_t'(12'h0a0 + n * 53);
  endfunction

  // Home bank is the tag modulo the bank count
  function automatic bank_t home_of(input tag_t t);
    return bank_t'(t % NUM_BANKS);
  endfunction

  // Lowest free slot of a model bank
  function automatic logic model_free(input int b, output slot_t s);
    logic found;
    found = 1'b0;
    s     = '0;
    for (int i = 0; i < BANK_DEPTH; i++) begin
      if (!m_valid[b][i] && !found) begin
        found = 1'b1;
        s     = slot_t'(i);
      end
    end
    return found;
  endfunction

  task automatic check_index(input string name, input dir_index_t expected,
                             input dir_index_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  // Drive one cycle of traffic, shaped by the test phase
  task automatic drive_stimulus(input int cyc);
    int    pick;
    slot_t fs;
    alloc.tag = pool_tag(int'($urandom_range(POOL_SIZE - 1)));
    pick      = int'($urandom_range(3));
    if (pick == 0) begin
      // Recently allocated tag that should hit
      search_tag = last_alloc_tag;
    end else if (pick == 1) begin
      // Tags outside the pool always miss
      search_tag = 12'hf00 | tag_t'($urandom_range(255));
    end else begin
      search_tag = pool_tag(int'($urandom_range(POOL_SIZE - 1)));
    end
    if (cyc < FILL_END) begin
      alloc.enable = ($urandom_range(9) != 0);
      evict        = '0;
    end else if (cyc < DRAIN_END) begin
      // Sweep every index including free slots
      alloc.enable = 1'b0;
      evict.enable = 1'b1;
      evict.index  = dir_index_t'(5'(cyc % 32));
    end else begin
      alloc.enable = ($urandom_range(9) < 6);
      evict.enable = ($urandom_range(9) < 4);
      pick         = int'($urandom_range(2));
      if (pick == 0) begin
        // Same slot the allocation targets
        void'(model_free(int'(home_of(alloc.tag)), fs));
        evict.index.bank  = home_of(alloc.tag);
        evict.index.slot  = fs;
      end else if (pick == 1) begin
        evict.index = exp_search_index;
      end else begin
        evict.index = dir_index_t'(5'($urandom_range(31)));
      end
    end
  endtask

  // Expected outputs from the model contents
  task automatic compute_expected();
    slot_t fs;
    logic  any_free;
    logic  found;
    bank_t hb;
    hb                   = home_of(alloc.tag);
    any_free             = model_free(int'(hb), fs);
    exp_blocked          = !any_free;
    exp_alloc_index.bank = hb;
    exp_alloc_index.slot = fs;
    // Lowest bank first, then lowest slot
    found            = 1'b0;
    exp_search_index = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int i = 0; i < BANK_DEPTH; i++) begin
        if (!found && m_valid[b][i] && m_tags[b][i] == search_tag) begin
          found                 = 1'b1;
          exp_search_index.bank = bank_t'(b);
          exp_search_index.slot = slot_t'(i);
        end
      end
    end
    exp_hit   = found;
    exp_full  = 1'b1;
    exp_empty = 1'b1;
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int i = 0; i < BANK_DEPTH; i++) begin
        exp_full  = exp_full && m_valid[b][i];
        exp_empty = exp_empty && !m_valid[b][i];
      end
    end
  endtask

  // Model state change at the rising edge with eviction applied last
  task automatic update_model();
    slot_t fs;
    bank_t hb;
    hb = home_of(alloc.tag);
    if (alloc.enable && model_free(int'(hb), fs)) begin
      m_valid[hb][fs] = 1'b1;
      m_tags[hb][fs]  = alloc.tag;
      last_alloc_tag  = alloc.tag;
      if (evict.enable && evict.index.bank == hb && evict.index.slot == fs) begin
        seen_collision++;
      end
    end
    if (evict.enable) begin
      m_valid[evict.index.bank][evict.index.slot] = 1'b0;
    end
  endtask

  // Watchdog sized from reset, run length and a margin
  initial begin
    #((RESET_CYCLES + RUN_CYCLES + 100) * 8);
    $display("Timeout: the test did not finish in the expected time");
    $display("RESULT: FAIL");
    $fatal(1);
  end

  initial begin
    void'($urandom(32'h03fd_357a));
    clock          = 1'b0;
    resetn         = 1'b0;
    alloc          = '0;
    search_tag     = '0;
    evict          = '0;
    last_alloc_tag = '0;
    seen_full      = 0;
    seen_drained   = 0;
    seen_blocked   = 0;
    seen_hit       = 0;
    seen_collision = 0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int i = 0; i < BANK_DEPTH; i++) begin
        m_valid[b][i] = 1'b0;
        m_tags[b][i]  = '0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    resetn = 1'b1;

    for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
      @(negedge clock);
      drive_stimulus(cyc);
      // Sample just ahead of the rising edge
      #3;
      compute_expected();
      check_flag("alloc_blocked", exp_blocked, alloc_blocked);
      check_index("alloc_index", exp_alloc_index, alloc_index);
      check_flag("search_hit", exp_hit, search_hit);
      if (exp_hit) begin
        check_index("search_index", exp_search_index, search_index);
      end
      check_flag("full", exp_full, full);
      check_flag("empty", exp_empty, empty);
      if (exp_full) seen_full++;
      if (exp_empty && cyc >= FILL_END) seen_drained++;
      if (exp_blocked && alloc.enable) seen_blocked++;
      if (exp_hit) seen_hit++;
      @(posedge clock);
      update_model();
    end

    // Make sure the interesting cases were reached
    if (seen_full == 0 || seen_drained == 0) begin
      $display("Coverage: the directory never went fully occupied and back to empty");
      $display("RESULT: FAIL");
      $fatal(1);
    end else if (seen_blocked == 0 || seen_hit == 0 || seen_collision == 0) begin
      $display("Coverage: no blocked allocation, search hit or same-slot eviction seen");
      $display("RESULT: FAIL");
      $fatal(1);
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule
